// File: common/axi_define.svh
`ifndef AXI_DEFINE_SVH
`define AXI_DEFINE_SVH

// Write data bus width in bits
`define AXI_DATA_BITS 32

// One strobe bit per data byte
`define AXI_STRB_BITS 4

// Byte address width
`define AXI_ADDR_BITS 16

`endif

// File: common/axi_pkg.sv
`include "axi_define.svh"

package axi_pkg;

  // Address split: slave select on top, then word offset, then byte lane
  localparam int SEL_FIELD_BITS  = 4;
  localparam int BYTE_FIELD_BITS = $clog2(`AXI_STRB_BITS);
  localparam int WORD_FIELD_BITS = `AXI_ADDR_BITS - SEL_FIELD_BITS - BYTE_FIELD_BITS;

  localparam int LEN_BITS = 8;

  typedef struct packed {
    logic [SEL_FIELD_BITS-1:0]  slv;
    logic [WORD_FIELD_BITS-1:0] word;
    logic [BYTE_FIELD_BITS-1:0] byte_off;
  } addr_fields_t;

  // Same address bits, seen flat or as select plus offsets
  typedef union packed {
    logic [`AXI_ADDR_BITS-1:0] raw;
    addr_fields_t              f;
  } wr_addr_u;

  typedef struct packed {
    wr_addr_u            addr;
    logic [LEN_BITS-1:0] len;
  } aw_chan_t;

  typedef struct packed {
    logic [`AXI_DATA_BITS-1:0] data;
    logic [`AXI_STRB_BITS-1:0] strb;
    logic                      last;
  } w_chan_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  // Single master, so the lock is just free or held
  typedef enum logic {
    ROUTE_FREE = 1'b0,
    ROUTE_BUSY = 1'b1
  } route_e;

endpackage

// File: xbar/aw_router.sv
`timescale 1ns/1ps

module aw_router #(
  parameter int NSLV     = 3,
  parameter int SEL_BITS = 2
) (
  input  logic                clk,
  input  logic                rstn,
  input  axi_pkg::aw_chan_t   aw,
  input  logic                awvalid,
  output logic                awready,
  output axi_pkg::aw_chan_t   s_aw,
  output logic [NSLV-1:0]     s_awvalid,
  input  logic                done,
  output logic [SEL_BITS-1:0] sel,
  output logic                busy
);

  import axi_pkg::*;

  route_e              route;
  route_e              route_next;
  logic [SEL_BITS-1:0] dec_sel;
  logic                aw_hs;

  // Out-of-map selects go to the last slave, which then flags SLVERR
  always_comb begin
    if (int'(aw.addr.f.slv) >= NSLV) begin
      dec_sel = SEL_BITS'(NSLV - 1);
    end else begin
      dec_sel = aw.addr.f.slv[SEL_BITS-1:0];
    end
  end

  assign awready = (route == ROUTE_FREE);
  assign aw_hs   = awvalid && awready;
  assign busy    = (route == ROUTE_BUSY);

  // Address beat is shared, only the valid is steered
  assign s_aw = aw;

  always_comb begin
    s_awvalid = '0;
    if (aw_hs) begin
      s_awvalid[dec_sel] = 1'b1;
    end
  end

  always_comb begin
    route_next = route;
    unique case (route)
      ROUTE_FREE: begin
        if (aw_hs) begin
          route_next = ROUTE_BUSY;
        end
      end
      ROUTE_BUSY: begin
        // Held until the response handshake
        if (done) begin
          route_next = ROUTE_FREE;
        end
      end
      default: route_next = ROUTE_FREE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      route <= ROUTE_FREE;
    end else begin
      route <= route_next;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sel <= '0;
    end else if (aw_hs) begin
      sel <= dec_sel;
    end
  end

endmodule

// File: xbar/w_router.sv
`timescale 1ns/1ps

module w_router #(
  parameter int NSLV     = 3,
  parameter int SEL_BITS = 2
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic [SEL_BITS-1:0] sel,
  input  logic                busy,
  input  axi_pkg::w_chan_t    w,
  input  logic                wvalid,
  output logic                wready,
  output axi_pkg::w_chan_t    s_w,
  output logic [NSLV-1:0]     s_wvalid,
  input  logic [NSLV-1:0]     s_wready
);

  import axi_pkg::*;

  w_chan_t w_q;
  logic    replay;
  logic    slv_ready;
  logic    fast_path;
  logic    slow_path;
  logic    capture;

  assign slv_ready = s_wready[sel];

  // Fresh beat from the master, or the held copy being replayed
  assign fast_path = busy && !replay && wvalid;
  assign slow_path = busy && replay;

  // Slave was not ready in the arrival cycle
  assign capture = fast_path && !slv_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      replay <= 1'b0;
    end else if (capture) begin
      replay <= 1'b1;
    end else if (slow_path && slv_ready) begin
      replay <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      w_q <= w;
    end
  end

  // Demux toward the routed slave
  always_comb begin
    s_w      = w;
    s_wvalid = '0;
    wready   = 1'b0;

    if (fast_path) begin
      s_wvalid[sel] = 1'b1;
      wready        = slv_ready;
    end else if (slow_path) begin
      s_w           = w_q;
      // Valid stays up until the slave takes the held beat
      s_wvalid[sel] = 1'b1;
      wready        = slv_ready;
    end
  end

endmodule

// File: xbar/b_merge.sv
`timescale 1ns/1ps

module b_merge #(
  parameter int NSLV     = 3,
  parameter int SEL_BITS = 2
) (
  input  logic [SEL_BITS-1:0]            sel,
  input  logic                           busy,
  input  axi_pkg::b_chan_t [NSLV-1:0]    s_b,
  input  logic [NSLV-1:0]                s_bvalid,
  output logic [NSLV-1:0]                s_bready,
  output axi_pkg::b_chan_t               b,
  output logic                           bvalid,
  input  logic                           bready,
  output logic                           done
);

  // Only the routed slave's response reaches the master
  always_comb begin
    b        = s_b[sel];
    bvalid   = busy && s_bvalid[sel];
    s_bready = '0;
    if (busy) begin
      s_bready[sel] = bready;
    end
  end

  // Route is released on the response handshake
  assign done = bvalid && bready;

endmodule

// File: hw/slave_ram.sv
`timescale 1ns/1ps
`include "axi_define.svh"

module slave_ram #(
  parameter int NSLV      = 3,
  parameter int RAM_WORDS = 64
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  axi_pkg::aw_chan_t            aw,
  input  logic                         awvalid,
  input  axi_pkg::w_chan_t             w,
  input  logic                         wvalid,
  output logic                         wready,
  input  logic                         stall,
  output axi_pkg::b_chan_t             b,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [$clog2(RAM_WORDS)-1:0] rd_word,
  output logic [`AXI_DATA_BITS-1:0]    rd_data
);

  import axi_pkg::*;

  localparam int IDX_BITS = $clog2(RAM_WORDS);
  // One spare bit so start word plus burst length cannot wrap
  localparam int PTR_BITS = WORD_FIELD_BITS + 1;

  logic [`AXI_DATA_BITS-1:0] mem [RAM_WORDS];

  logic [PTR_BITS-1:0] ptr;
  logic [LEN_BITS-1:0] beats_left;
  logic                bad_sel;
  logic                in_burst;
  logic                err;
  logic                w_hs;
  logic                in_range;
  logic                last_beat;
  logic                beat_err;

  assign wready    = in_burst && !stall;
  assign w_hs      = wvalid && wready;
  assign in_range  = !bad_sel && (int'(ptr) < RAM_WORDS);
  assign last_beat = (beats_left == '0);

  // Out of range, or WLAST disagreeing with AWLEN
  assign beat_err = !in_range || (w.last != last_beat);

  // Burst start, INCR only
  always_ff @(posedge clk) begin
    if (awvalid) begin
      ptr        <= PTR_BITS'(aw.addr.f.word);
      beats_left <= aw.len;
      bad_sel    <= (int'(aw.addr.f.slv) >= NSLV);
    end else if (w_hs) begin
      ptr        <= ptr + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      in_burst <= 1'b0;
      bvalid   <= 1'b0;
      err      <= 1'b0;
    end else begin
      if (awvalid) begin
        in_burst <= 1'b1;
        err      <= 1'b0;
      end else if (w_hs) begin
        err <= err || beat_err;
        if (w.last) begin
          in_burst <= 1'b0;
        end
      end

      if (w_hs && w.last) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_hs && w.last) begin
      b.resp <= (err || beat_err) ? SLVERR : OKAY;
    end
  end

  // Byte lanes under strobe
  always_ff @(posedge clk) begin
    if (w_hs && in_range) begin
      for (int i = 0; i < `AXI_STRB_BITS; i++) begin
        if (w.strb[i]) begin
          mem[ptr[IDX_BITS-1:0]][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

  assign rd_data = mem[rd_word];

endmodule

// File: hw/axi_wr_fabric.sv
`timescale 1ns/1ps
`include "axi_define.svh"

module axi_wr_fabric #(
  parameter int NSLV      = 3,
  parameter int SEL_BITS  = 2,
  parameter int RAM_WORDS = 64
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  axi_pkg::aw_chan_t            aw,
  input  logic                         awvalid,
  output logic                         awready,
  input  axi_pkg::w_chan_t             w,
  input  logic                         wvalid,
  output logic                         wready,
  output axi_pkg::b_chan_t             b,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [NSLV-1:0]              stall,
  input  logic [SEL_BITS-1:0]          rd_sel,
  input  logic [$clog2(RAM_WORDS)-1:0] rd_word,
  output logic [`AXI_DATA_BITS-1:0]    rd_data
);

  import axi_pkg::*;

  aw_chan_t               s_aw;
  logic [NSLV-1:0]        s_awvalid;
  w_chan_t                s_w;
  logic [NSLV-1:0]        s_wvalid;
  logic [NSLV-1:0]        s_wready;
  b_chan_t [NSLV-1:0]     s_b;
  logic [NSLV-1:0]        s_bvalid;
  logic [NSLV-1:0]        s_bready;
  logic [SEL_BITS-1:0]    sel;
  logic                   busy;
  logic                   done;

  logic [`AXI_DATA_BITS-1:0] slv_rd_data [NSLV];

  aw_router #(
    .NSLV    (NSLV),
    .SEL_BITS(SEL_BITS)
  ) u_aw_router (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (aw),
    .awvalid  (awvalid),
    .awready  (awready),
    .s_aw     (s_aw),
    .s_awvalid(s_awvalid),
    .done     (done),
    .sel      (sel),
    .busy     (busy)
  );

  w_router #(
    .NSLV    (NSLV),
    .SEL_BITS(SEL_BITS)
  ) u_w_router (
    .clk     (clk),
    .rstn    (rstn),
    .sel     (sel),
    .busy    (busy),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .s_w     (s_w),
    .s_wvalid(s_wvalid),
    .s_wready(s_wready)
  );

  for (genvar i = 0; i < NSLV; i++) begin : g_slv
    slave_ram #(
      .NSLV     (NSLV),
      .RAM_WORDS(RAM_WORDS)
    ) u_ram (
      .clk    (clk),
      .rstn   (rstn),
      .aw     (s_aw),
      .awvalid(s_awvalid[i]),
      .w      (s_w),
      .wvalid (s_wvalid[i]),
      .wready (s_wready[i]),
      .stall  (stall[i]),
      .b      (s_b[i]),
      .bvalid (s_bvalid[i]),
      .bready (s_bready[i]),
      .rd_word(rd_word),
      .rd_data(slv_rd_data[i])
    );
  end

  b_merge #(
    .NSLV    (NSLV),
    .SEL_BITS(SEL_BITS)
  ) u_b_merge (
    .sel     (sel),
    .busy    (busy),
    .s_b     (s_b),
    .s_bvalid(s_bvalid),
    .s_bready(s_bready),
    .b       (b),
    .bvalid  (bvalid),
    .bready  (bready),
    .done    (done)
  );

  // Read-back for the testbench, zero for a select with no slave
  assign rd_data = (int'(rd_sel) < NSLV) ? slv_rd_data[rd_sel] : '0;

endmodule

// File: dv/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int HALF_PERIOD = 10,
  parameter int RST_CYCLES  = 3
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Reset released just after the last reset edge
  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rstn = 1'b1;
  end

endmodule

// File: dv/tb_axi_wr_fabric.sv
`timescale 1ns/1ps
`include "axi_define.svh"

module tb_axi_wr_fabric;

  import axi_pkg::*;

  localparam int NSLV       = 3;
  localparam int SEL_BITS   = 2;
  localparam int RAM_WORDS  = 64;
  localparam int WAIT_LIMIT = 200;

  logic                         clk;
  logic                         rstn;
  aw_chan_t                     aw;
  logic                         awvalid;
  logic                         awready;
  w_chan_t                      w;
  logic                         wvalid;
  logic                         wready;
  b_chan_t                      b;
  logic                         bvalid;
  logic                         bready;
  logic [NSLV-1:0]              stall;
  logic [SEL_BITS-1:0]          rd_sel;
  logic [$clog2(RAM_WORDS)-1:0] rd_word;
  logic [`AXI_DATA_BITS-1:0]    rd_data;

  logic [31:0] lfsr_state;
  int          error_count;

  // Byte image of every slave RAM
  logic [7:0] model_mem [NSLV][RAM_WORDS*4];

  clk_rst_gen u_clk_rst (
    .clk (clk),
    .rstn(rstn)
  );

  axi_wr_fabric #(
    .NSLV     (NSLV),
    .SEL_BITS (SEL_BITS),
    .RAM_WORDS(RAM_WORDS)
  ) dut0 (
    .clk    (clk),
    .rstn   (rstn),
    .aw     (aw),
    .awvalid(awvalid),
    .awready(awready),
    .w      (w),
    .wvalid (wvalid),
    .wready (wready),
    .b      (b),
    .bvalid (bvalid),
    .bready (bready),
    .stall  (stall),
    .rd_sel (rd_sel),
    .rd_word(rd_word),
    .rd_data(rd_data)
  );

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 32'h8020_0003;
    end
    return s;
  endfunction

  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v[i]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [`AXI_DATA_BITS-1:0] model_word(input int s, input int wd);
    logic [`AXI_DATA_BITS-1:0] v;
    for (int i = 0; i < `AXI_STRB_BITS; i++) begin
      v[8*i +: 8] = model_mem[s][wd*4 + i];
    end
    return v;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic stop_with_failure(input string why);
    error_count++;
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, why);
  endtask

  task automatic report_mismatch(input string line);
    error_count++;
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "first mismatch");
  endtask

  task automatic check_data(input logic [`AXI_DATA_BITS-1:0] exp,
                            input logic [`AXI_DATA_BITS-1:0] got, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("MISMATCH at %0t: %s expected %h got %h",
                                $time, what, exp, got));
    end
  endtask

  task automatic check_resp(input b_chan_t exp, input b_chan_t got, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("MISMATCH at %0t: %s expected resp %b got %b",
                                $time, what, exp.resp, got.resp));
    end
  endtask

  task automatic check_flag(input logic exp, input logic got, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("MISMATCH at %0t: %s expected %b got %b",
                                $time, what, exp, got));
    end
  endtask

  task automatic do_burst(input int slv, input int word, input int beats,
                          input bit full_strb, input bit use_stall);
    aw_chan_t a;
    b_chan_t  exp_b;
    int       tgt;
    int       idx;
    int       cnt;
    int       delay;
    bit       err;
    tgt = (slv >= NSLV) ? NSLV - 1 : slv;
    err = 1'b0;
    a.addr.f.slv      = SEL_FIELD_BITS'(slv);
    a.addr.f.word     = WORD_FIELD_BITS'(word);
    a.addr.f.byte_off = BYTE_FIELD_BITS'(draw(2));
    a.len             = LEN_BITS'(beats - 1);

    tick();
    aw      = a;
    awvalid = 1'b1;
    cnt     = 0;
    @(negedge clk);
    while (awready !== 1'b1) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        stop_with_failure("Timeout: the AW channel never handshook");
      end
      tick();
      @(negedge clk);
    end
    tick();
    awvalid = 1'b0;

    for (int k = 0; k < beats; k++) begin
      w.data = draw(`AXI_DATA_BITS);
      w.strb = full_strb ? '1 : `AXI_STRB_BITS'(draw(`AXI_STRB_BITS));
      w.last = (k == beats - 1);
      wvalid = 1'b1;
      stall  = '0;
      // Stall on arrival forces the replay register
      if (use_stall) begin
        stall[tgt] = draw(1);
      end
      cnt = 0;
      @(negedge clk);
      while (wready !== 1'b1) begin
        check_flag(1'b0, awready, "awready during burst");
        cnt++;
        if (cnt > WAIT_LIMIT) begin
          stop_with_failure("Timeout: the W channel never handshook");
        end
        tick();
        stall[tgt] = (draw(2) == 3);
        @(negedge clk);
      end
      check_flag(1'b0, awready, "awready during burst");
      idx = word + k;
      if (slv < NSLV && idx < RAM_WORDS) begin
        for (int i = 0; i < `AXI_STRB_BITS; i++) begin
          if (w.strb[i]) begin
            model_mem[slv][idx*4 + i] = w.data[8*i +: 8];
          end
        end
      end else begin
        err = 1'b1;
      end
      tick();
    end
    wvalid     = 1'b0;
    stall      = '0;
    exp_b.resp = err ? SLVERR : OKAY;

    // A second address waits while the route is held
    aw.addr.raw = `AXI_ADDR_BITS'(draw(`AXI_ADDR_BITS));
    aw.len      = LEN_BITS'(draw(2));
    awvalid     = 1'b1;
    delay       = draw(2);
    cnt         = 0;
    @(negedge clk);
    while (bvalid !== 1'b1) begin
      check_flag(1'b0, awready, "awready before response");
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        stop_with_failure("Timeout: the B channel never raised bvalid");
      end
      tick();
      @(negedge clk);
    end
    check_resp(exp_b, b, "write response");
    for (int d = 0; d < delay; d++) begin
      check_flag(1'b0, awready, "awready while response pending");
      tick();
      @(negedge clk);
      check_flag(1'b1, bvalid, "bvalid held under back-pressure");
      check_resp(exp_b, b, "held write response");
    end
    tick();
    bready = 1'b1;
    @(negedge clk);
    check_flag(1'b1, bvalid, "bvalid at handshake");
    check_flag(1'b0, awready, "awready at response handshake");
    tick();
    bready  = 1'b0;
    awvalid = 1'b0;
    @(negedge clk);
    check_flag(1'b0, bvalid, "bvalid after handshake");
    check_flag(1'b1, awready, "awready after response");
  endtask

  task automatic verify_all();
    for (int s = 0; s < NSLV; s++) begin
      for (int wd = 0; wd < RAM_WORDS; wd++) begin
        tick();
        rd_sel  = SEL_BITS'(s);
        rd_word = wd;
        @(negedge clk);
        check_data(model_word(s, wd), rd_data, $sformatf("slave %0d word %0d", s, wd));
      end
    end
  endtask

  initial begin
    int cnt;
    int slv;
    int word;
    aw          = '0;
    awvalid     = 1'b0;
    w           = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    stall       = '0;
    rd_sel      = '0;
    rd_word     = '0;
    lfsr_state  = 32'hd535;
    error_count = 0;

    cnt = 0;
    while (rstn !== 1'b1) begin
      cnt++;
      if (cnt > 20) begin
        stop_with_failure("Reset was never released");
      end
      @(posedge clk);
    end
    tick();
    @(negedge clk);
    check_flag(1'b1, awready, "awready after reset");
    check_flag(1'b0, wready, "wready after reset");
    check_flag(1'b0, bvalid, "bvalid after reset");

    // Known contents everywhere before the random traffic
    for (int s = 0; s < NSLV; s++) begin
      for (int wd = 0; wd < RAM_WORDS; wd += 4) begin
        do_burst(s, wd, 4, 1'b1, 1'b0);
      end
    end
    verify_all();

    for (int n = 0; n < 60; n++) begin
      slv  = draw(2);
      word = draw(6);
      if (draw(3) == 0) begin
        word = word + 512;
      end
      do_burst(slv, word, draw(2) + 1, draw(1), 1'b1);
      verify_all();
    end

    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: axi_wr_fabric.f
+incdir+common
common/axi_pkg.sv
xbar/aw_router.sv
xbar/w_router.sv
xbar/b_merge.sv
hw/slave_ram.sv
hw/axi_wr_fabric.sv
dv/clk_rst_gen.sv
dv/tb_axi_wr_fabric.sv
